/* compile.f */
design/ipdc_pkg.sv
design/ipdc_ctrl.sv
design/window_scan.sv
design/pixel_buffer.sv
design/ycbcr_conv.sv
design/ipdc_top.sv
sim/tb_ipdc.sv

/* sim/ipdc_golden.txt */
// Word 0 is the operation count, then 64 pixels RRGGBB in raster order, 8 per line
// Each record is an opcode; opcodes 1 to 4 are followed by 16 expected words, one window row per line
00000F
// Image: pixel a = 8y+x holds R=4a, G=128-2a, B=3a
008000 047E03 087C06 0C7A09 10780C 14760F 187412 1C7215
207018 246E1B 286C1E 2C6A21 306824 346627 38642A 3C622D
406030 445E33 485C36 4C5A39 50583C 54563F 585442 5C5245
605048 644E4B 684C4E 6C4A51 704854 744657 78445A 7C425D
804060 843E63 883C66 8C3A69 90386C 94366F 983472 9C3275
A03078 A42E7B A82C7E AC2A81 B02884 B42687 B8248A BC228D
C02090 C41E93 C81C96 CC1A99 D0189C D4169F D814A2 DC12A5
E010A8 E40EAB E80CAE EC0AB1 F008B4 F406B7 F804BA FC02BD
0 // load
3 // default, RGB window at (0,0)
008000 047E03 087C06 0C7A09
207018 246E1B 286C1E 2C6A21
406030 445E33 485C36 4C5A39
605048 644E4B 684C4E 6C4A51
4 // zoom, RGB window at (2,2)
485C36 4C5A39 50583C 54563F
684C4E 6C4A51 704854 744657
883C66 8C3A69 90386C 94366F
A82C7E AC2A81 B02884 B42687
1 // shift right to (3,2)
4C5A39 50583C 54563F 585442
6C4A51 704854 744657 78445A
8C3A69 90386C 94366F 983472
AC2A81 B02884 B42687 B8248A
1 // shift right to (4,2)
50583C 54563F 585442 5C5245
704854 744657 78445A 7C425D
90386C 94366F 983472 9C3275
B02884 B42687 B8248A BC228D
1 // shift right, x stays at 4
50583C 54563F 585442 5C5245
704854 744657 78445A 7C425D
90386C 94366F 983472 9C3275
B02884 B42687 B8248A BC228D
2 // shift down to (4,3)
704854 744657 78445A 7C425D
90386C 94366F 983472 9C3275
B02884 B42687 B8248A BC228D
D0189C D4169F D814A2 DC12A5
2 // shift down to (4,4)
90386C 94366F 983472 9C3275
B02884 B42687 B8248A BC228D
D0189C D4169F D814A2 DC12A5
F008B4 F406B7 F804BA FC02BD
2 // shift down, y stays at 4
90386C 94366F 983472 9C3275
B02884 B42687 B8248A BC228D
D0189C D4169F D814A2 DC12A5
F008B4 F406B7 F804BA FC02BD
7 // YCbCr mode
3 // default, YCbCr window at (0,0) as CrCbY
585850 5A5950 5C5B50 5E5C50
676351 696551 6B6651 6D6851
776F52 797052 7B7252 7D7352
867A53 887C53 8A7D53 8C7F53
5 // reserved, no effect
1 // shift right to (1,0), still YCbCr
5A5950 5C5B50 5E5C50 605E50
696551 6B6651 6D6851 6F6951
797052 7B7252 7D7352 7F7552
887C53 8A7D53 8C7F53 8E8053
6 // RGB mode
4 // zoom, RGB window at (2,2)
485C36 4C5A39 50583C 54563F
684C4E 6C4A51 704854 744657
883C66 8C3A69 90386C 94366F
A82C7E AC2A81 B02884 B42687

/* sim/tb_ipdc.sv */
// Run from the project root so sim/ipdc_golden.txt is found; the output side is never stalled
module tb_ipdc
    import ipdc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD    = 4;
    localparam int RESET_CYCLES   = 3;
    localparam int IMG_PIX        = IMG_DIM * IMG_DIM;
    localparam int GOLD_WORDS     = 256;
    localparam int CYCLES_PER_OP  = 200;
    localparam int CYCLES_PER_PIX = 4;
    localparam int RAND_SEED      = 33491;
    // Cycles from trigger edge to first visible beat
    localparam int DISP_LAT       = 2;
    localparam int DONE_LAT       = 1;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             op_valid;
    op_e              op_mode;
    logic             in_valid;
    logic [PIX_W-1:0] in_data;
    logic             op_ready;
    logic             in_ready;
    logic             out_valid;
    logic [PIX_W-1:0] out_data;

    logic [PIX_W-1:0] gold [GOLD_WORDS];
    logic [PIX_W-1:0] beat_data [$];
    int               beat_cyc [$];
    int               cyc = 0;
    int               val_errors = 0;
    int               proto_errors = 0;
    int               wd_cycles = 0;

    ipdc_top i_ipdc_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_op_valid  (op_valid),
        .i_op_mode   (op_mode),
        .i_in_valid  (in_valid),
        .i_in_data   (in_data),
        .o_op_ready  (op_ready),
        .o_in_ready  (in_ready),
        .o_out_valid (out_valid),
        .o_out_data  (out_data)
    );

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Output beats are collected mid-cycle
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            beat_data.push_back(out_data);
            beat_cyc.push_back(cyc);
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_pixel(input logic [PIX_W-1:0] got, input logic [PIX_W-1:0] exp,
                               input int op_no, input int beat);
        if (got !== exp) begin
            val_errors++;
            $display("ERR o_out_data op %0d beat %0d: got %06h, expected %06h",
                     op_no, beat, got, exp);
        end
    endtask

    task automatic check_done(input logic [PIX_W-1:0] got, input int op_no);
        if (got !== '0) begin
            val_errors++;
            $display("ERR o_out_data op %0d completion beat: got %06h, expected %06h",
                     op_no, got, {PIX_W{1'b0}});
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            val_errors++;
            $display("ERR %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    // Shift, default and zoom stream a window
    function automatic bit expects_window(input op_e op);
        case (op)
            OP_SHIFT_RIGHT, OP_SHIFT_DOWN, OP_DEFAULT, OP_ZOOM: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // --------------------------------------------------
    // Drivers entered and left on a falling edge
    // --------------------------------------------------
    task automatic issue_op(input op_e op, output int acc_cyc);
        op_valid = 1'b1;
        op_mode  = op;
        while (!op_ready) @(negedge clk);
        acc_cyc = cyc + 1;
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic load_pixels(output int last_cyc);
        int idx;
        bit taken;
        idx = 0;
        while (idx < IMG_PIX) begin
            in_valid = (($urandom % 4) != 0);
            in_data  = gold[1 + idx];
            taken    = in_valid && in_ready;
            if (taken) last_cyc = cyc + 1;
            @(negedge clk);
            if (taken) idx++;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_idle(output int idle_cyc);
        while (!op_ready) @(negedge clk);
        idle_cyc = cyc;
    endtask

    task automatic review_beats(input int op_no, input bit window, input int exp_idx,
                                input int trig_cyc, input int idle_cyc);
        int n_exp;
        int lat;
        int i;
        n_exp = window ? WIN_PIX : 1;
        lat   = window ? DISP_LAT : DONE_LAT;
        if (beat_data.size() != n_exp) begin
            proto_errors++;
            $display("Operation %0d produced %0d output beats instead of %0d",
                     op_no, beat_data.size(), n_exp);
        end else begin
            if (beat_cyc[0] != trig_cyc + lat) begin
                proto_errors++;
                $display("Operation %0d started its output %0d cycles after the trigger, not %0d",
                         op_no, beat_cyc[0] - trig_cyc, lat);
            end
            for (i = 0; i < n_exp; i++) begin
                if (beat_cyc[i] != beat_cyc[0] + i) begin
                    proto_errors++;
                    $display("Operation %0d output beat %0d is not on a consecutive cycle",
                             op_no, i);
                end
                if (window) begin
                    check_pixel(beat_data[i], gold[exp_idx + i], op_no, i);
                end else begin
                    check_done(beat_data[i], op_no);
                end
            end
            if (idle_cyc != beat_cyc[n_exp-1] + 1) begin
                proto_errors++;
                $display("Operation %0d raised o_op_ready %0d cycles after its last beat, not 1",
                         op_no, idle_cyc - beat_cyc[n_exp-1]);
            end
        end
        beat_data.delete();
        beat_cyc.delete();
    endtask

    task automatic end_run();
        $display("tb_ipdc: %0d value errors, %0d protocol errors", val_errors, proto_errors);
        if (val_errors + proto_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int  n_ops;
        int  ptr;
        int  trig;
        int  idle;
        int  k;
        op_e op;
        bit  window;

        void'($urandom(RAND_SEED));
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op_mode  = OP_LOAD;
        in_valid = 1'b0;
        in_data  = '0;

        $readmemh("sim/ipdc_golden.txt", gold);
        n_ops = $isunknown(gold[0]) ? 0 : int'(gold[0]);
        if (n_ops > 0) begin
            wd_cycles = n_ops * CYCLES_PER_OP + IMG_PIX * CYCLES_PER_PIX + RESET_CYCLES;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        compare_flag("o_op_ready", op_ready, 1'b1);
        compare_flag("o_in_ready", in_ready, 1'b0);
        compare_flag("o_out_valid", out_valid, 1'b0);

        if (n_ops == 0) begin
            proto_errors++;
            $display("Golden file sim/ipdc_golden.txt is missing or lists no operations");
        end else begin
            ptr = 1 + IMG_PIX;
            for (k = 0; k < n_ops; k++) begin
                op = op_e'(gold[ptr][2:0]);
                ptr++;
                window = expects_window(op);
                issue_op(op, trig);
                if (op == OP_LOAD) begin
                    // Pixel port opens the cycle after the load is taken
                    compare_flag("o_in_ready", in_ready, 1'b1);
                    load_pixels(trig);
                end
                wait_idle(idle);
                review_beats(k, window, ptr, trig, idle);
                if (window) ptr += WIN_PIX;
            end
            repeat (4) @(negedge clk);
            if (beat_data.size() != 0) begin
                proto_errors++;
                $display("DUT produced %0d output beats after the last operation",
                         beat_data.size());
            end
            if (ptr != GOLD_WORDS) begin
                proto_errors++;
                $display("Golden file holds %0d words but the records used %0d", GOLD_WORDS, ptr);
            end
        end
        end_run();
    end

    // Watchdog armed once the operation count is known
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        proto_errors++;
        $display("Run timed out after %0d cycles before all operations finished", wd_cycles);
        end_run();
    end

endmodule

/* design/ipdc_top.sv */
// No output back-pressure; the downstream sink must take every o_out_valid beat
module ipdc_top
    import ipdc_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_op_valid,
    input  op_e              i_op_mode,
    input  logic             i_in_valid,
    input  logic [PIX_W-1:0] i_in_data,
    output logic             o_op_ready,
    output logic             o_in_ready,
    output logic             o_out_valid,
    output logic [PIX_W-1:0] o_out_data
);

    logic               wr_en;
    logic [ADDR_W-1:0]  wr_addr;
    logic               scan_start;
    logic               scan_done;
    logic [COORD_W-1:0] origin_x;
    logic [COORD_W-1:0] origin_y;
    disp_mode_e         disp_mode;
    logic               done_pulse;
    logic [ADDR_W-1:0]  rd_addr;
    logic               rd_valid;
    logic [PIX_W-1:0]   buf_data;
    logic               buf_valid;

    ipdc_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op_valid   (i_op_valid),
        .i_op_mode    (i_op_mode),
        .i_in_valid   (i_in_valid),
        .i_scan_done  (scan_done),
        .o_op_ready   (o_op_ready),
        .o_in_ready   (o_in_ready),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_scan_start (scan_start),
        .o_origin_x   (origin_x),
        .o_origin_y   (origin_y),
        .o_disp_mode  (disp_mode),
        .o_done_pulse (done_pulse)
    );

    window_scan u_scan (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (scan_start),
        .i_origin_x (origin_x),
        .i_origin_y (origin_y),
        .o_rd_addr  (rd_addr),
        .o_rd_valid (rd_valid),
        .o_done     (scan_done)
    );

    // Pixel data goes straight into the buffer, ctrl only supplies the address
    pixel_buffer u_buf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (i_in_data),
        .i_rd_addr  (rd_addr),
        .i_rd_valid (rd_valid),
        .o_rd_data  (buf_data),
        .o_rd_valid (buf_valid)
    );

    ycbcr_conv u_conv (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pix        (buf_data),
        .i_pix_valid  (buf_valid),
        .i_done_pulse (done_pulse),
        .i_mode       (disp_mode),
        .o_pix        (o_out_data),
        .o_pix_valid  (o_out_valid)
    );

endmodule

/* design/ycbcr_conv.sv */
// Mode is sampled per beat; a completion beat always carries zero data
module ycbcr_conv
    import ipdc_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [PIX_W-1:0] i_pix,
    input  logic             i_pix_valid,
    input  logic             i_done_pulse,
    input  disp_mode_e       i_mode,
    output logic [PIX_W-1:0] o_pix,
    output logic             o_pix_valid
);

    logic [CH_W-1:0]   r, g, b;
    logic [CH_W+2:0]   y_sum;
    logic [CH_W-1:0]   y;
    logic signed [9:0] cb_diff, cr_diff;
    logic signed [9:0] cb_sum, cr_sum;

    assign {r, g, b} = i_pix;

    // 2R + 5G + B, then floor divide by 8
    assign y_sum = {r, 1'b0} + {g, 2'b00} + g + b;
    assign y     = y_sum[CH_W+2:3];

    // Arithmetic shift gives floor for negative differences
    assign cb_diff = $signed({2'b00, b}) - $signed({2'b00, y});
    assign cr_diff = $signed({2'b00, r}) - $signed({2'b00, y});
    assign cb_sum  = 10'sd128 + (cb_diff >>> 1);
    assign cr_sum  = 10'sd128 + (cr_diff >>> 1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pix_valid <= 1'b0;
        end else begin
            o_pix_valid <= i_pix_valid | i_done_pulse;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_done_pulse) begin
            o_pix <= '0;
        end else if (i_mode == MODE_YCBCR) begin
            o_pix <= {cr_sum[CH_W-1:0], cb_sum[CH_W-1:0], y};
        end else begin
            o_pix <= i_pix;
        end
    end

endmodule

/* design/pixel_buffer.sv */
// Write and read must not target the buffer in the same cycle; read data is undefined until loaded
module pixel_buffer
    import ipdc_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wr_en,
    input  logic [ADDR_W-1:0] i_wr_addr,
    input  logic [PIX_W-1:0]  i_wr_data,
    input  logic [ADDR_W-1:0] i_rd_addr,
    input  logic              i_rd_valid,
    output logic [PIX_W-1:0]  o_rd_data,
    output logic              o_rd_valid
);

    // One memory per channel, B in channel 0
    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        logic [CH_W-1:0] mem [IMG_DIM*IMG_DIM];
        logic [CH_W-1:0] rd_q;

        always_ff @(posedge i_clk) begin
            if (i_wr_en) begin
                mem[i_wr_addr] <= i_wr_data[c*CH_W +: CH_W];
            end
            if (i_rd_valid) begin
                rd_q <= mem[i_rd_addr];
            end
        end

        assign o_rd_data[c*CH_W +: CH_W] = rd_q;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_rd_valid;
        end
    end

endmodule

/* design/window_scan.sv */
// Origin must stay within 0..4 so the 4x4 window never crosses the image edge
module window_scan
    import ipdc_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  logic [COORD_W-1:0] i_origin_x,
    input  logic [COORD_W-1:0] i_origin_y,
    output logic [ADDR_W-1:0]  o_rd_addr,
    output logic               o_rd_valid,
    output logic               o_done
);

    localparam int OFS_W  = $clog2(WIN_PIX);
    localparam int HALF_W = $clog2(WIN_DIM);

    logic               active;
    logic [OFS_W-1:0]   offset;
    logic [COORD_W-1:0] pos_x;
    logic [COORD_W-1:0] pos_y;

    // Low half steps x, high half steps y
    assign pos_x = i_origin_x + COORD_W'(offset[HALF_W-1:0]);
    assign pos_y = i_origin_y + COORD_W'(offset[OFS_W-1:HALF_W]);

    assign o_rd_addr  = {pos_y, pos_x};
    assign o_rd_valid = i_start | active;
    assign o_done     = o_rd_valid & (offset == OFS_W'(WIN_PIX - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active <= 1'b0;
            offset <= '0;
        end else if (o_rd_valid) begin
            // Offset wraps back to 0 on the last address
            offset <= offset + 1'b1;
            active <= ~o_done;
        end
    end

endmodule

/* design/ipdc_ctrl.sv */
// One operation at a time; opcode 5 is reserved and completes like a mode op with no effect
module ipdc_ctrl
    import ipdc_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_op_valid,
    input  op_e                i_op_mode,
    input  logic               i_in_valid,
    input  logic               i_scan_done,
    output logic               o_op_ready,
    output logic               o_in_ready,
    output logic               o_wr_en,
    output logic [ADDR_W-1:0]  o_wr_addr,
    output logic               o_scan_start,
    output logic [COORD_W-1:0] o_origin_x,
    output logic [COORD_W-1:0] o_origin_y,
    output disp_mode_e         o_disp_mode,
    output logic               o_done_pulse
);

    ctrl_state_e       state;
    logic              op_accept;
    logic              pix_accept;
    logic              is_display;
    logic              scan_done_q;
    logic [ADDR_W-1:0] load_cnt;

    assign o_op_ready   = (state == ST_IDLE);
    assign o_in_ready   = (state == ST_LOAD);
    assign op_accept    = i_op_valid & o_op_ready;
    assign pix_accept   = i_in_valid & o_in_ready;
    assign is_display   = (i_op_mode inside {OP_SHIFT_RIGHT, OP_SHIFT_DOWN, OP_DEFAULT, OP_ZOOM});
    assign o_wr_en      = pix_accept;
    assign o_wr_addr    = load_cnt;
    // Completion beat for load as well as mode ops
    assign o_done_pulse = (state == ST_LOAD_DONE);

    // --------------------------------------------------
    // Main FSM
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (op_accept) begin
                        if (i_op_mode == OP_LOAD) begin
                            state <= ST_LOAD;
                        end else if (is_display) begin
                            state <= ST_DISPLAY;
                        end else begin
                            state <= ST_LOAD_DONE;
                        end
                    end
                end
                ST_LOAD: begin
                    if (pix_accept && (&load_cnt)) begin
                        state <= ST_LOAD_DONE;
                    end
                end
                ST_LOAD_DONE: state <= ST_FINISH;
                // Wait for the last read to clear the buffer stage
                ST_DISPLAY: begin
                    if (scan_done_q) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Raster write address, wraps to 0 after the 64th pixel
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_cnt <= '0;
        end else if (pix_accept) begin
            load_cnt <= load_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Origin, mode and scan kick-off
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_origin_x   <= '0;
            o_origin_y   <= '0;
            o_disp_mode  <= MODE_RGB;
            o_scan_start <= 1'b0;
            scan_done_q  <= 1'b0;
        end else begin
            o_scan_start <= op_accept & is_display;
            scan_done_q  <= i_scan_done;
            if (op_accept) begin
                case (i_op_mode)
                    OP_SHIFT_RIGHT: begin
                        if (o_origin_x < COORD_W'(ORIGIN_MAX)) begin
                            o_origin_x <= o_origin_x + 1'b1;
                        end
                    end
                    OP_SHIFT_DOWN: begin
                        if (o_origin_y < COORD_W'(ORIGIN_MAX)) begin
                            o_origin_y <= o_origin_y + 1'b1;
                        end
                    end
                    OP_DEFAULT: begin
                        o_origin_x <= '0;
                        o_origin_y <= '0;
                    end
                    OP_ZOOM: begin
                        o_origin_x <= COORD_W'(ZOOM_ORIGIN);
                        o_origin_y <= COORD_W'(ZOOM_ORIGIN);
                    end
                    OP_MODE_RGB:   o_disp_mode <= MODE_RGB;
                    OP_MODE_YCBCR: o_disp_mode <= MODE_YCBCR;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* design/ipdc_pkg.sv */
// Sizes are fixed by the 8x8, 24-bit RGB image format and are not independent knobs
package ipdc_pkg;

    // --------------------------------------------------
    // Image and window geometry
    // --------------------------------------------------
    localparam int PIX_W       = 24;
    localparam int CH_W        = 8;
    localparam int NUM_CH      = 3;
    localparam int IMG_DIM     = 8;
    localparam int COORD_W     = 3;
    localparam int WIN_DIM     = 4;
    localparam int WIN_PIX     = 16;
    // Buffer address is {y, x}
    localparam int ADDR_W      = 6;
    localparam int ORIGIN_MAX  = 4;
    localparam int ZOOM_ORIGIN = 2;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        OP_LOAD        = 3'd0,
        OP_SHIFT_RIGHT = 3'd1,
        OP_SHIFT_DOWN  = 3'd2,
        OP_DEFAULT     = 3'd3,
        OP_ZOOM        = 3'd4,
        OP_RESERVED    = 3'd5,
        OP_MODE_RGB    = 3'd6,
        OP_MODE_YCBCR  = 3'd7
    } op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_LOAD_DONE,
        ST_DISPLAY,
        ST_FINISH
    } ctrl_state_e;

    typedef enum logic {
        MODE_RGB,
        MODE_YCBCR
    } disp_mode_e;

endpackage
